// ==== all.f ====
src/screen_pkg.sv
src/screen_regs.sv
src/screen_fetch.sv
src/vram_buffer.sv
src/blink_screen.sv
verification/clk_gen.sv
verification/screen_fetch_sva.sv
verification/tb_blink_screen.sv

// ==== Makefile ====
# Verilator build and run for the Blink screen fetch path
# Any variable below can be set on the make command line

VERILATOR ?= verilator
TOP       ?= tb_blink_screen
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
FAIL_MSG  ?= *** FAILED ***
PASS_MSG  ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the fail line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tb_blink_screen.sv ====
// --------------------
// Blink screen testbench
// Table driven frames against a memory model and a pixel reference
// --------------------
module tb_blink_screen;

    localparam int LINES   = 64;
    localparam int COLS    = 109;
    localparam int VRAM_AW = 14;
    localparam int ROWS    = 4;

    logic                    mck;
    logic                    rst_n;
    logic [1:0]              clkcnt = 2'd0;    // Free running bus phase
    logic                    reg_we;
    screen_pkg::screen_reg_e reg_sel;
    logic [12:0]             reg_wdata;
    logic [7:0]              cdi;
    logic [21:0]             va;
    logic [VRAM_AW-1:0]      disp_addr;
    logic [3:0]              disp_data;
    logic                    frame_done;

    // --------------------
    // Stimulus table, one frame per row
    // Mode 0 all hires, 1 all lores, 2 mixed, 3 reverse heavy
    // Nibbles per line in pure rows or 0 for the model count
    // SBR bit 10 set and map base top bits clear keep map reads off attributes
    logic [12:0] tab_pb0  [ROWS] = '{13'h0123, 13'h0a55, 13'h0f0c, 13'h0333};
    logic [9:0]  tab_pb1  [ROWS] = '{10'h1a5, 10'h0c3, 10'h155, 10'h07e};
    logic [8:0]  tab_pb2  [ROWS] = '{9'h0b4, 9'h05a, 9'h0ff, 9'h0c1};
    logic [10:0] tab_pb3  [ROWS] = '{11'h2f1, 11'h11e, 11'h3a3, 11'h0d6};
    logic [10:0] tab_sbr  [ROWS] = '{11'h5c0, 11'h7a1, 11'h4ff, 11'h632};
    int          tab_mode [ROWS] = '{0, 1, 2, 3};
    int          tab_nibs [ROWS] = '{218, 164, 0, 0};

    // Memory model and reference state
    logic [31:0] salt;
    int          mode;
    logic [10:0] cur_sbr;
    logic [3:0]  exp_vram [2**VRAM_AW];
    int          line_nibs [LINES];
    int          wr_count;
    int          model_total;

    clk_gen #(.PERIOD(20), .RST_CYCLES(16)) u_clk (.mck(mck), .rst_n(rst_n));

    blink_screen #(.LINES(LINES), .COLS(COLS), .VRAM_AW(VRAM_AW)) u_dut (
        .mck(mck), .rst_n(rst_n), .clkcnt(clkcnt),
        .reg_we(reg_we), .reg_sel(reg_sel), .reg_wdata(reg_wdata),
        .cdi(cdi), .va(va),
        .disp_addr(disp_addr), .disp_data(disp_data), .frame_done(frame_done)
    );

    always @(posedge mck) clkcnt <= clkcnt + 2'd1;

    // Memory answers in the same cycle
    function automatic logic [7:0] mem_byte(input logic [21:0] a, input logic [31:0] s,
                                            input int m, input logic [10:0] base);
        logic [31:0] h;
        logic [7:0]  b;
        h = ({10'd0, a} * 32'h9e3779b1) ^ s;
        h = h ^ (h >> 15);
        b = h[7:0] ^ h[23:16];
        if (a[21:11] == base && a[0]) begin            // Attribute high byte, steered
            b[screen_pkg::ATTR_HRS] = (m == 0) ? 1'b1 : (m == 1) ? 1'b0 : h[29];
            b[screen_pkg::ATTR_REV] = (m == 3);
        end
        return b;
    endfunction

    always_comb cdi = mem_byte(va, salt, mode, cur_sbr);

    // --------------------
    // Failure and compare tasks
    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_va(input string what, input logic [21:0] got, input logic [21:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("[FAIL] va (%s): got %06h exp %06h", what, got, exp));
        end
    endtask

    task automatic check_reg_sel_effect(input screen_pkg::screen_reg_e sel,
                                        input logic [12:0] got, input logic [12:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("[FAIL] va map base via %s: got %04h exp %04h",
                                sel.name(), got, exp));
        end
    endtask

    task automatic check_nibble(input logic [VRAM_AW-1:0] a, input logic [3:0] got,
                                input logic [3:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("[FAIL] disp_data at %04h: got %h exp %h", a, got, exp));
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            fail_stop($sformatf("[FAIL] %s: got %0h exp %0h", what, got, exp));
        end
    endtask

    // --------------------
    // Bus and sampling helpers
    task automatic write_reg(input screen_pkg::screen_reg_e sel, input logic [12:0] data);
        @(posedge mck);
        reg_we    <= 1'b1;
        reg_sel   <= sel;
        reg_wdata <= data;
        @(posedge mck);
        reg_we    <= 1'b0;
    endtask

    // Falling edge sampling that also counts VRAM writes
    task automatic tick(input int n);
        repeat (n) begin
            @(negedge mck);
            if (u_dut.vram_we === 1'b1) wr_count++;
        end
    endtask

    task automatic put_nibble(input int ln, inout int n, input logic [3:0] v);
        exp_vram[{6'(ln), 8'(n)}] = v;
        n++;
    endtask

    // Follows every cell of one frame, checks both addresses, builds the VRAM image
    task automatic run_frame(input int r);
        logic [21:0] attr_a;
        logic [21:0] map_a;
        logic [7:0]  lo;
        logic [7:0]  hi;
        logic [7:0]  pix;
        logic [8:0]  sba;
        logic [2:0]  rw;
        logic [1:0]  carry;
        logic        carry_f;
        logic [12:0] base;
        int          shift;
        int          n;
        int          k;
        screen_pkg::screen_reg_e sel;
        k = 0;
        do begin                                    // First cell opens at phase 2
            tick(1);
            k++;
            if (k > 8) fail_stop("no bus phase 2 within 8 cycles of LCD on");
        end while (clkcnt != 2'd2);
        model_total = 0;
        for (int ln = 0; ln < LINES; ln++) begin
            n       = 0;
            carry   = 2'b00;
            carry_f = 1'b0;
            rw      = 3'(ln);
            for (int c = 0; c < COLS; c++) begin
                attr_a = {tab_sbr[r], 3'(ln >> 3), 7'(c), 1'b0};
                tick(2);
                check_va("attribute", va, attr_a);
                lo  = mem_byte(attr_a, salt, mode, cur_sbr);
                hi  = mem_byte(attr_a | 22'd1, salt, mode, cur_sbr);
                sba = {hi[screen_pkg::ATTR_SBA8], lo};
                if (!hi[screen_pkg::ATTR_HRS] && sba[8:6] == 3'b111) begin
                    sel   = screen_pkg::REG_PB0;            // Lores0
                    base  = tab_pb0[r];
                    shift = 9;
                    map_a = {tab_pb0[r], sba[5:0], rw};
                end else if (!hi[screen_pkg::ATTR_HRS]) begin
                    sel   = screen_pkg::REG_PB1;            // Lores1
                    base  = 13'(tab_pb1[r]);
                    shift = 12;
                    map_a = {tab_pb1[r], sba, rw};
                end else if (hi[screen_pkg::ATTR_UND] && sba[8]) begin
                    sel   = screen_pkg::REG_PB3;            // Hires1
                    base  = 13'(tab_pb3[r]);
                    shift = 11;
                    map_a = {tab_pb3[r], sba[7:0], rw};
                end else begin
                    sel   = screen_pkg::REG_PB2;            // Hires0
                    base  = 13'(tab_pb2[r]);
                    shift = 13;
                    map_a = {tab_pb2[r], hi[screen_pkg::ATTR_UND], sba, rw};
                end
                tick(4);
                check_reg_sel_effect(sel, 13'(va >> shift), base);
                check_va("pixel map", va, map_a);
                pix = mem_byte(map_a, salt, mode, cur_sbr) ^ {8{hi[screen_pkg::ATTR_REV]}};
                if (hi[screen_pkg::ATTR_HRS]) begin
                    put_nibble(ln, n, pix[7:4]);
                    put_nibble(ln, n, pix[3:0]);
                    carry_f = 1'b0;                         // Waiting pair is lost
                end else if (!carry_f) begin
                    put_nibble(ln, n, pix[5:2]);
                    carry   = pix[1:0];
                    carry_f = 1'b1;
                end else begin
                    put_nibble(ln, n, {carry, pix[5:4]});
                    put_nibble(ln, n, pix[3:0]);
                    carry_f = 1'b0;
                end
                tick(2);
            end
            if (carry_f) put_nibble(ln, n, {carry, 2'b00});  // Line end padding
            line_nibs[ln] = n;
            model_total  += n;
        end
        k = 0;
        while (frame_done !== 1'b1) begin
            tick(1);
            k++;
            if (k > 16) fail_stop("frame_done missing after the last cell of the frame");
        end
        tick(1);
        if (frame_done !== 1'b0) fail_stop("frame_done high for more than one cycle");
    endtask

    // va frozen and no frame pulse while LCD off
    task automatic check_lcd_off();
        logic [21:0] held;
        @(negedge mck);
        held = va;
        for (int i = 0; i < 24; i++) begin
            @(negedge mck);
            check_va("held with LCD off", va, held);
            if (frame_done !== 1'b0) fail_stop("frame_done high while the LCD is off");
        end
    endtask

    task automatic read_back();
        logic [VRAM_AW-1:0] a;
        for (int ln = 0; ln < LINES; ln++) begin
            for (int n = 0; n < line_nibs[ln]; n++) begin
                a = {6'(ln), 8'(n)};
                @(posedge mck);
                disp_addr <= a;
                @(posedge mck);
                @(negedge mck);                     // Registered read lands here
                check_nibble(a, disp_data, exp_vram[a]);
            end
        end
    endtask

    // --------------------
    // Main sequence
    initial begin
        int k;
        reg_we    = 1'b0;
        reg_sel   = screen_pkg::REG_PB0;
        reg_wdata = 13'd0;
        disp_addr = '0;
        salt      = 32'd0;
        mode      = 0;
        cur_sbr   = 11'd0;
        wr_count  = 0;
        void'($urandom(32'h5140975a));
        k = 0;
        while (rst_n !== 1'b1) begin
            @(posedge mck);
            k++;
            if (k > 64) fail_stop("reset was never released");
        end
        check_lcd_off();
        for (int r = 0; r < ROWS; r++) begin
            salt    = $urandom;                     // New memory contents per row
            mode    = tab_mode[r];
            cur_sbr = tab_sbr[r];
            write_reg(screen_pkg::REG_PB0, tab_pb0[r]);
            write_reg(screen_pkg::REG_PB1, 13'(tab_pb1[r]));
            write_reg(screen_pkg::REG_PB2, 13'(tab_pb2[r]));
            write_reg(screen_pkg::REG_PB3, 13'(tab_pb3[r]));
            write_reg(screen_pkg::REG_SBR, 13'(tab_sbr[r]));
            wr_count = 0;
            write_reg(screen_pkg::REG_COM, 13'd1);
            run_frame(r);
            write_reg(screen_pkg::REG_COM, 13'd0);
            check_count("VRAM writes in frame", wr_count,
                        (tab_nibs[r] != 0) ? tab_nibs[r] * LINES : model_total);
            check_lcd_off();
            read_back();
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== verification/screen_fetch_sva.sv ====
// --------------------
// Fetch engine assertions
// Bus phases, VRAM write strobes and LCD off behaviour
// --------------------
module screen_fetch_sva (
    input logic                     mck,
    input logic                     rst_n,
    input logic                     lcdon,
    input logic [1:0]               clkcnt,
    input logic [21:0]              va,
    input logic                     vram_we,
    input logic                     frame_done,
    input screen_pkg::fetch_state_e step
);

    // Address moves only at phase 2 setup, or on the odd attribute byte
    va_phase: assert property (@(posedge mck) disable iff (!rst_n)
        !$stable(va) |-> ($past(clkcnt) == 2'd2) || (va[21:1] == $past(va[21:1])))
        else $error("va changed outside bus phase 2");

    // At most two nibble writes back to back in a cell
    we_burst: assert property (@(posedge mck) disable iff (!rst_n)
        vram_we && $past(vram_we) |-> !$past(vram_we, 2))
        else $error("vram_we high three cycles in a row");

    // Engine parked while LCD off
    fd_off: assert property (@(posedge mck) disable iff (!rst_n)
        !lcdon && !$past(lcdon) |-> !frame_done)
        else $error("frame_done high with LCD off");

    step_off: assert property (@(posedge mck) disable iff (!rst_n)
        !lcdon && !$past(lcdon) |-> step == screen_pkg::ATTR)
        else $error("fetch step not ATTR with LCD off");

endmodule

bind screen_fetch screen_fetch_sva u_sva (
    .mck(mck), .rst_n(rst_n), .lcdon(lcdon), .clkcnt(clkcnt), .va(va),
    .vram_we(vram_we), .frame_done(frame_done), .step(step)
);

// ==== verification/clk_gen.sv ====
// --------------------
// Testbench clock and reset
// --------------------
module clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 16
) (
    output logic mck,
    output logic rst_n
);

    initial begin
        mck = 1'b0;
        forever #(PERIOD / 2) mck = ~mck;
    end

    // Reset held low for a fixed cycle count
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge mck);
        rst_n <= 1'b1;                      // Release on a rising edge
    end

endmodule

// ==== src/blink_screen.sv ====
// --------------------
// Blink screen top
// Registers, fetch engine and VRAM buffer
// --------------------
module blink_screen #(
    parameter int LINES   = 64,
    parameter int COLS    = 109,
    parameter int VRAM_AW = 14
) (
    input  logic                     mck,
    input  logic                     rst_n,
    input  logic [1:0]               clkcnt,
    // CPU register port
    input  logic                     reg_we,
    input  screen_pkg::screen_reg_e  reg_sel,
    input  logic [12:0]              reg_wdata,
    // System memory
    input  logic [7:0]               cdi,
    output logic [21:0]              va,
    // Display side
    input  logic [VRAM_AW-1:0]       disp_addr,
    output logic [3:0]               disp_data,
    output logic                     frame_done
);

    logic [screen_pkg::PB0_W-1:0] pb0;
    logic [screen_pkg::PB1_W-1:0] pb1;
    logic [screen_pkg::PB2_W-1:0] pb2;
    logic [screen_pkg::PB3_W-1:0] pb3;
    logic [screen_pkg::SBR_W-1:0] sbr;
    logic                         lcdon;
    logic [VRAM_AW-1:0]           vram_a;     // Fetch to buffer
    logic [3:0]                   vram_do;
    logic                         vram_we;

    screen_regs u_regs (
        .mck(mck), .rst_n(rst_n),
        .reg_we(reg_we), .reg_sel(reg_sel), .reg_wdata(reg_wdata),
        .pb0(pb0), .pb1(pb1), .pb2(pb2), .pb3(pb3), .sbr(sbr),
        .lcdon(lcdon)
    );

    screen_fetch #(.LINES(LINES), .COLS(COLS), .VRAM_AW(VRAM_AW)) u_fetch (
        .mck(mck), .rst_n(rst_n), .lcdon(lcdon), .clkcnt(clkcnt),
        .pb0(pb0), .pb1(pb1), .pb2(pb2), .pb3(pb3), .sbr(sbr),
        .cdi(cdi), .va(va),
        .vram_a(vram_a), .vram_do(vram_do), .vram_we(vram_we),
        .frame_done(frame_done)
    );

    // Display reads one cycle after address
    vram_buffer #(.VRAM_AW(VRAM_AW)) u_vram (
        .mck(mck),
        .we(vram_we), .wa(vram_a), .wd(vram_do),
        .ra(disp_addr), .rd(disp_data)
    );

endmodule

// ==== src/vram_buffer.sv ====
// --------------------
// VRAM nibble buffer
// Simple dual port, fetch writes, display reads registered
// --------------------
module vram_buffer #(
    parameter int VRAM_AW = 14
) (
    input  logic               mck,
    // Write port from fetch
    input  logic               we,
    input  logic [VRAM_AW-1:0] wa,
    input  logic [3:0]         wd,
    // Read port to display
    input  logic [VRAM_AW-1:0] ra,
    output logic [3:0]         rd
);

    localparam int DEPTH = 2 ** VRAM_AW;   // Line x nibble index

    logic [3:0] mem [DEPTH];

    // --------------------
    // Write on the clock edge
    always_ff @(posedge mck) begin
        if (we) begin
            mem[wa] <= wd;
        end
    end

    // Registered read, one cycle latency
    always_ff @(posedge mck) begin
        rd <= mem[ra];
    end

endmodule

// ==== src/screen_fetch.sv ====
// --------------------
// Blink screen fetch engine
// Reads attributes and pixel bytes in the free bus phases, packs nibbles to VRAM
// --------------------
module screen_fetch #(
    parameter int LINES   = 64,
    parameter int COLS    = 109,
    parameter int VRAM_AW = 14
) (
    input  logic                          mck,
    input  logic                          rst_n,
    input  logic                          lcdon,
    input  logic [1:0]                    clkcnt,     // Bus phase 0..3
    // Screen registers
    input  logic [screen_pkg::PB0_W-1:0]  pb0,
    input  logic [screen_pkg::PB1_W-1:0]  pb1,
    input  logic [screen_pkg::PB2_W-1:0]  pb2,
    input  logic [screen_pkg::PB3_W-1:0]  pb3,
    input  logic [screen_pkg::SBR_W-1:0]  sbr,
    // Memory bus
    input  logic [7:0]                    cdi,
    output logic [21:0]                   va,
    // VRAM write port
    output logic [VRAM_AW-1:0]            vram_a,
    output logic [3:0]                    vram_do,
    output logic                          vram_we,
    output logic                          frame_done
);

    localparam int NIB_W  = 8;                  // Nibble index within a line
    localparam int LINE_W = VRAM_AW - NIB_W;    // Line part of VRAM address
    localparam int COL_W  = $clog2(COLS);

    localparam logic [COL_W-1:0]  COL_LAST  = COL_W'(COLS - 1);
    localparam logic [LINE_W-1:0] LINE_LAST = LINE_W'(LINES - 1);

    // Control state
    screen_pkg::fetch_state_e step;
    logic                     armed;    // First address loaded since LCD on
    logic [LINE_W-1:0]        line;
    logic [COL_W-1:0]         col;
    logic [NIB_W-1:0]         nib;
    logic                     carry_f;  // Two lores pixels waiting
    logic                     pend;     // Second nibble of cell waiting
    logic                     frame_end;

    // Payload
    logic [7:0]               sba_lo;   // Attribute low byte
    logic [5:0]               attr_hi;  // HRS REV FLS GRY UND SBA8
    logic [1:0]               carry;
    logic [3:0]               pix4b;

    // Decoded attribute, flash and grey stay unused
    logic                     hrs;
    logic                     rev;
    logic                     und;
    logic [8:0]               sba;
    logic [7:0]               pix;
    logic [2:0]               row;
    logic [21:0]              map_va;

    // Phase strobes
    logic                     ld_attr;
    logic                     cap_lo;
    logic                     cap_hi;
    logic                     ld_map;
    logic                     cap_pix;
    logic                     cell_end;
    logic                     last_col;
    logic                     wr2;      // Write at end of cell

    assign hrs = attr_hi[screen_pkg::ATTR_HRS];
    assign rev = attr_hi[screen_pkg::ATTR_REV];
    assign und = attr_hi[screen_pkg::ATTR_UND];
    assign sba = {attr_hi[screen_pkg::ATTR_SBA8], sba_lo};
    assign pix = cdi ^ {8{rev}};              // Reverse video
    assign row = line[2:0];                   // Pixel row inside char

    // --------------------
    // Bus phase decode
    // Phase 2 belongs to the Z80, only address setup there
    assign ld_attr  = lcdon && (step == screen_pkg::ATTR) && (clkcnt == 2'd2);
    assign cap_lo   = lcdon && armed && (step == screen_pkg::ATTR) && (clkcnt == 2'd0);
    assign cap_hi   = lcdon && armed && (step == screen_pkg::ATTR) && (clkcnt == 2'd1);
    assign ld_map   = lcdon && (step == screen_pkg::PIXEL) && (clkcnt == 2'd2);
    assign cap_pix  = lcdon && (step == screen_pkg::PIXEL) && (clkcnt == 2'd0);
    assign cell_end = lcdon && (step == screen_pkg::PIXEL) && (clkcnt == 2'd1);
    assign last_col = (col == COL_LAST);
    assign wr2      = pend || (last_col && carry_f);   // Second nibble or line flush

    // Character map address from attribute
    always_comb begin
        if (!hrs) begin
            if (sba[8:6] == 3'b111) begin
                map_va = {pb0, sba[5:0], row};        // Lores0 ROM, 64 chars
            end else begin
                map_va = {pb1, sba, row};             // Lores1 RAM
            end
        end else if (und && sba[8]) begin
            map_va = {pb3, sba[7:0], row};            // Hires1 RAM
        end else begin
            map_va = {pb2, und, sba, row};            // Hires0 ROM
        end
    end

    // --------------------
    // Sequencing, counters and write strobes
    always_ff @(posedge mck or negedge rst_n) begin
        if (!rst_n) begin
            step       <= screen_pkg::ATTR;
            armed      <= 1'b0;
            line       <= '0;
            col        <= '0;
            nib        <= '0;
            carry_f    <= 1'b0;
            pend       <= 1'b0;
            vram_we    <= 1'b0;
            frame_end  <= 1'b0;
            frame_done <= 1'b0;
        end else if (!lcdon) begin
            // LCD off, engine parked at line 0 column 0
            step       <= screen_pkg::ATTR;
            armed      <= 1'b0;
            line       <= '0;
            col        <= '0;
            nib        <= '0;
            carry_f    <= 1'b0;
            pend       <= 1'b0;
            vram_we    <= 1'b0;
            frame_end  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            vram_we    <= 1'b0;
            frame_end  <= 1'b0;
            frame_done <= frame_end;                  // One cycle after last write
            if (ld_attr) begin
                armed <= 1'b1;
            end
            if (cap_hi) begin
                step <= screen_pkg::PIXEL;
            end
            if (cap_pix) begin
                vram_we <= 1'b1;                      // Every cell writes here
                nib     <= nib + 1'b1;
                if (hrs || carry_f) begin
                    carry_f <= 1'b0;                  // Hires drops a lores carry
                    pend    <= 1'b1;
                end else begin
                    carry_f <= 1'b1;
                    pend    <= 1'b0;
                end
            end
            if (cell_end) begin
                step    <= screen_pkg::ATTR;
                pend    <= 1'b0;
                vram_we <= wr2;
                if (last_col) begin
                    col     <= '0;
                    nib     <= '0;                    // New line restarts index
                    carry_f <= 1'b0;
                    if (line == LINE_LAST) begin
                        line      <= '0;
                        frame_end <= 1'b1;
                    end else begin
                        line <= line + 1'b1;
                    end
                end else begin
                    col <= col + 1'b1;
                    if (wr2) begin
                        nib <= nib + 1'b1;
                    end
                end
            end
        end
    end

    // --------------------
    // Address, attribute and pixel data path
    always_ff @(posedge mck) begin
        if (ld_attr) begin
            va <= {sbr, line[LINE_W-1 -: 3], col, 1'b0};    // Attribute low byte
        end
        if (cap_lo) begin
            sba_lo <= cdi;
            va[0]  <= 1'b1;                           // Odd byte next
        end
        if (cap_hi) begin
            attr_hi <= cdi[5:0];                      // FLS and GRY kept, not acted on
        end
        if (ld_map) begin
            va <= map_va;
        end
        if (cap_pix) begin
            vram_a <= {line, nib};
            if (hrs) begin
                vram_do <= pix[7:4];
                pix4b   <= pix[3:0];
            end else if (carry_f) begin
                vram_do <= {carry, pix[5:4]};         // Old pair plus two new
                pix4b   <= pix[3:0];
            end else begin
                vram_do <= pix[5:2];                  // Lores pixels are bits 5..0
                carry   <= pix[1:0];
            end
        end
        if (cell_end) begin
            vram_a  <= {line, nib};
            vram_do <= pend ? pix4b : {carry, 2'b00}; // End of line pads two zeros
        end
    end

endmodule

// ==== src/screen_regs.sv ====
// --------------------
// Blink screen registers
// Map bases PB0-PB3, screen base SBR and the LCD on bit
// --------------------
module screen_regs (
    input  logic                          mck,
    input  logic                          rst_n,
    // CPU write port
    input  logic                          reg_we,
    input  screen_pkg::screen_reg_e       reg_sel,
    input  logic [12:0]                   reg_wdata,
    // Register outputs to fetch
    output logic [screen_pkg::PB0_W-1:0]  pb0,
    output logic [screen_pkg::PB1_W-1:0]  pb1,
    output logic [screen_pkg::PB2_W-1:0]  pb2,
    output logic [screen_pkg::PB3_W-1:0]  pb3,
    output logic [screen_pkg::SBR_W-1:0]  sbr,
    output logic                          lcdon
);

    // --------------------
    // Register write
    // All clear on reset, LCD off
    always_ff @(posedge mck or negedge rst_n) begin
        if (!rst_n) begin
            pb0   <= '0;
            pb1   <= '0;
            pb2   <= '0;
            pb3   <= '0;
            sbr   <= '0;
            lcdon <= 1'b0;
        end else if (reg_we) begin
            case (reg_sel)
                screen_pkg::REG_PB0: begin
                    pb0 <= reg_wdata[screen_pkg::PB0_W-1:0];     // Full 13 bits
                end
                screen_pkg::REG_PB1: begin
                    pb1 <= reg_wdata[screen_pkg::PB1_W-1:0];
                end
                screen_pkg::REG_PB2: begin
                    pb2 <= reg_wdata[screen_pkg::PB2_W-1:0];
                end
                screen_pkg::REG_PB3: begin
                    pb3 <= reg_wdata[screen_pkg::PB3_W-1:0];
                end
                screen_pkg::REG_SBR: begin
                    sbr <= reg_wdata[screen_pkg::SBR_W-1:0];
                end
                screen_pkg::REG_COM: begin
                    lcdon <= reg_wdata[0];                       // Only the LCD bit here
                end
                default: begin
                    // Unused selector codes, nothing written
                end
            endcase
        end
    end

endmodule

// ==== src/screen_pkg.sv ====
// --------------------
// Blink screen package
// Register selector, fetch step and attribute bit layout
// --------------------
package screen_pkg;

    // Register selector on the CPU port
    typedef enum logic [2:0] {
        REG_PB0 = 3'd0,     // Lores0 map base
        REG_PB1 = 3'd1,     // Lores1 map base
        REG_PB2 = 3'd2,     // Hires0 map base
        REG_PB3 = 3'd3,     // Hires1 map base
        REG_SBR = 3'd4,     // Screen base file
        REG_COM = 3'd5      // Command, bit 0 is LCD on
    } screen_reg_e;

    // Fetch engine step within one cell
    typedef enum logic {
        ATTR  = 1'b0,       // Two attribute bytes
        PIXEL = 1'b1        // One pixel byte from a map
    } fetch_state_e;

    // --------------------
    // Attribute high byte bit positions
    localparam int ATTR_HRS  = 5;   // Hires cell, 8 pixels
    localparam int ATTR_REV  = 4;   // Reverse video
    localparam int ATTR_FLS  = 3;   // Flash
    localparam int ATTR_GRY  = 2;   // Grey
    localparam int ATTR_UND  = 1;   // Underline, extra map bit in hires
    localparam int ATTR_SBA8 = 0;   // Char code bit 8

    // Register widths
    localparam int PB0_W = 13;
    localparam int PB1_W = 10;
    localparam int PB2_W = 9;
    localparam int PB3_W = 11;
    localparam int SBR_W = 11;

endpackage
